// File: verilog/cpuPkg.sv
/*
  Shared types for the MIPS32 execute stage.
  Datapath is fixed at 32 bits; nothing here is parameterized.
  Only the integer ALU subset is encoded. No mult/div, branch or memory ops.
  Exception flags only travel down the pipe and are handled after MEM.
*/
package cpuPkg;

    // alu operations, variable shifts share the fixed-shift codes
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        ADDU = 4'd1,
        SUB  = 4'd2,
        SUBU = 4'd3,
        AND  = 4'd4,
        OR   = 4'd5,
        XOR  = 4'd6,
        NOR  = 4'd7,
        SLT  = 4'd8,
        SLTU = 4'd9,
        SLL  = 4'd10,
        SRL  = 4'd11,
        SRA  = 4'd12,
        LUI  = 4'd13
    } aluOp_t;

    // where operand B (and the shift amount) comes from
    typedef enum logic [1:0] {
        REG     = 2'd0, // rt value
        SIGNIMM = 2'd1, // imm16 sign extended
        ZEROIMM = 2'd2, // imm16 zero extended
        SHAMT   = 2'd3  // rt on B, shamt field on A
    } operandSrc_t;

    // per-instruction exception flags, first field is the MSB
    typedef struct packed {
        logic wrongAddressInIf;
        logic reservedInstruction;
        logic syscall;
        logic breakPoint;
        logic eret;
        logic wrWrongAddressInMem;
        logic rdWrongAddressInMem;
        logic overflow;
    } exceptType_t;

    // ID/EX payload, 104 bits
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] rsValue;
        logic [31:0] rtValue;
        exceptType_t except;
    } idExBundle_t;

    // EX/MEM payload, 46 bits
    typedef struct packed {
        logic [31:0] aluResult;
        logic [4:0]  destReg;
        logic        regWrite;
        exceptType_t except;
    } exMemBundle_t;

    localparam logic [4:0] REG_ZERO = 5'd0; // hardwired zero register

    // opcode field
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // funct field of SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

endpackage

// File: verilog/pipeReg.sv
/*
  One-entry pipeline register for any packed payload.
  clear beats hold, so a flush lands even during a stall.
  Data is not reset and only loads with a valid entry;
  read outData only while outValid is high.
*/
`timescale 1ns/1ps

module pipeReg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     hold,     // stall from downstream
    input  logic     clear,    // drop the entry
    input  logic     inValid,
    input  payload_t inData,
    output logic     outValid,
    output payload_t outData
);

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else if (clear) begin
            outValid <= 1'b0;
        end else if (!hold) begin
            outValid <= inValid;
        end
    end

    // payload only moves with a valid entry, fewer toggles
    always_ff @(posedge clk) begin
        if (!hold && inValid) begin
            outData <= inData;
        end
    end

    validKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(outValid))
        else $error("pipeReg: outValid unknown");

endmodule

// File: verilog/exeControl.sv
/*
  Execute-stage decoder, purely combinational.
  Handles SPECIAL ALU functs and the eight immediate ALU opcodes only;
  everything else is flagged as a reserved instruction.
  Write enable drops on any exception, incoming or raised here.
*/
`timescale 1ns/1ps

module exeControl
    import cpuPkg::*;
(
    input  logic [31:0]  instr,
    input  exceptType_t  inExcept,
    input  logic         overflow,  // from alu, same cycle
    output aluOp_t       aluOp,
    output operandSrc_t  bSrc,
    output logic         aShamt,
    output logic [4:0]   destReg,
    output logic         regWrite,
    output exceptType_t  outExcept
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       reserved;  // unknown encoding
    logic       writes;    // decoded write intent
    logic       anyIn;     // some flag arrived from earlier stages

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign anyIn  = |inExcept;

    always_comb begin
        // ADDU default, so garbage never raises overflow
        aluOp    = ADDU;
        bSrc     = REG;
        aShamt   = 1'b0;
        destReg  = instr[15:11]; // rd
        writes   = 1'b1;
        reserved = 1'b0;
        if (opcode == OP_SPECIAL) begin
            case (funct)
                FN_SLL: begin
                    aluOp  = SLL;
                    bSrc   = SHAMT;
                    aShamt = 1'b1;
                end
                FN_SRL: begin
                    aluOp  = SRL;
                    bSrc   = SHAMT;
                    aShamt = 1'b1;
                end
                FN_SRA: begin
                    aluOp  = SRA;
                    bSrc   = SHAMT;
                    aShamt = 1'b1;
                end
                FN_SLLV: aluOp = SLL; // amount from rs[4:0]
                FN_SRLV: aluOp = SRL;
                FN_SRAV: aluOp = SRA;
                FN_ADD:  aluOp = ADD;
                FN_ADDU: aluOp = ADDU;
                FN_SUB:  aluOp = SUB;
                FN_SUBU: aluOp = SUBU;
                FN_AND:  aluOp = AND;
                FN_OR:   aluOp = OR;
                FN_XOR:  aluOp = XOR;
                FN_NOR:  aluOp = NOR;
                FN_SLT:  aluOp = SLT;
                FN_SLTU: aluOp = SLTU;
                default: begin
                    reserved = 1'b1;
                    writes   = 1'b0;
                end
            endcase
        end else begin
            destReg = instr[20:16]; // rt for I-type
            bSrc    = SIGNIMM;
            case (opcode)
                OP_ADDI:  aluOp = ADD;
                OP_ADDIU: aluOp = ADDU; // still sign extended
                OP_SLTI:  aluOp = SLT;
                OP_SLTIU: aluOp = SLTU; // sign extended, compared unsigned
                OP_ANDI: begin
                    aluOp = AND;
                    bSrc  = ZEROIMM;
                end
                OP_ORI: begin
                    aluOp = OR;
                    bSrc  = ZEROIMM;
                end
                OP_XORI: begin
                    aluOp = XOR;
                    bSrc  = ZEROIMM;
                end
                OP_LUI: begin
                    aluOp = LUI;
                    bSrc  = ZEROIMM;
                end
                default: begin
                    reserved = 1'b1;
                    writes   = 1'b0;
                end
            endcase
        end
    end

    // r0 is never written, any exception kills the write
    assign regWrite = writes && (destReg != REG_ZERO) && !anyIn && !overflow;

    always_comb begin
        outExcept                     = inExcept; // pass-through
        outExcept.reservedInstruction = inExcept.reservedInstruction | reserved;
        outExcept.overflow            = inExcept.overflow | overflow;
    end

endmodule

// File: verilog/operandSelect.sv
/*
  ALU operand muxing with EX/MEM forwarding.
  Only the immediately preceding instruction is forwarded; results still
  in write-back must already be in the register-file values.
  Register 0 is never forwarded.
*/
`timescale 1ns/1ps

module operandSelect
    import cpuPkg::*;
(
    input  logic [31:0]  instr,
    input  logic [31:0]  rsValue,
    input  logic [31:0]  rtValue,
    input  operandSrc_t  bSrc,
    input  logic         aShamt,
    input  exMemBundle_t fwd,      // EX/MEM register output
    input  logic         fwdValid,
    output logic [31:0]  operandA,
    output logic [31:0]  operandB
);

    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
    logic        fwdOk;    // older entry may be forwarded at all
    logic [31:0] rsFwd;
    logic [31:0] rtFwd;

    assign rs  = instr[25:21];
    assign rt  = instr[20:16];
    assign imm = instr[15:0];

    assign fwdOk = fwdValid && fwd.regWrite && (fwd.destReg != REG_ZERO);

    assign rsFwd = (fwdOk && fwd.destReg == rs) ? fwd.aluResult : rsValue;
    assign rtFwd = (fwdOk && fwd.destReg == rt) ? fwd.aluResult : rtValue;

    // fixed shifts take shamt, variable shifts just use rs (alu masks to 5 bits)
    assign operandA = aShamt ? {27'd0, instr[10:6]} : rsFwd;

    always_comb begin
        case (bSrc)
            SIGNIMM: operandB = {{16{imm[15]}}, imm};
            ZEROIMM: operandB = {16'd0, imm};
            default: operandB = rtFwd; // REG and SHAMT both shift/use rt
        endcase
    end

endmodule

// File: verilog/alu.sv
/*
  32-bit integer ALU, combinational.
  Shifts move operand B by operandA[4:0].
  Overflow only for the trapping ADD and SUB; the unsigned forms never trap.
  Unused operation codes give a zero result.
*/
`timescale 1ns/1ps

module alu
    import cpuPkg::*;
(
    input  aluOp_t      aluOp,
    input  logic [31:0] operandA,
    input  logic [31:0] operandB,
    output logic [31:0] result,
    output logic        overflow
);

    logic [31:0] sum;
    logic [31:0] diff;
    logic [4:0]  shiftAmt;
    logic        addOvf;
    logic        subOvf;

    assign sum      = operandA + operandB;
    assign diff     = operandA - operandB;
    assign shiftAmt = operandA[4:0];

    always_comb begin
        result = '0; // no latch on unused codes
        case (aluOp)
            ADD, ADDU: result = sum;
            SUB, SUBU: result = diff;
            AND:       result = operandA & operandB;
            OR:        result = operandA | operandB;
            XOR:       result = operandA ^ operandB;
            NOR:       result = ~(operandA | operandB);
            SLT:       result = {31'd0, $signed(operandA) < $signed(operandB)};
            SLTU:      result = {31'd0, operandA < operandB};
            SLL:       result = operandB << shiftAmt;
            SRL:       result = operandB >> shiftAmt;
            SRA:       result = $signed(operandB) >>> shiftAmt; // sign fill
            LUI:       result = operandB << 16;
            default:   result = '0;
        endcase
    end

    // same-sign inputs, result sign flipped
    assign addOvf = (operandA[31] == operandB[31]) && (sum[31] != operandA[31]);
    // differing signs, result takes B's sign
    assign subOvf = (operandA[31] != operandB[31]) && (diff[31] != operandA[31]);

    always_comb begin
        case (aluOp)
            ADD:     overflow = addOvf;
            SUB:     overflow = subOvf;
            default: overflow = 1'b0;
        endcase
    end

endmodule

// File: verilog/executeStage.sv
/*
  MIPS32 execute stage: ID/EX register, decode, operand mux, ALU, EX/MEM register.
  Latency is two cycles from issue to memBundle when not stalled.
  Upstream holds its issue inputs while stall is high.
  flush is a one-cycle pulse and kills the entry in ID/EX.
*/
`timescale 1ns/1ps

module executeStage
    import cpuPkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         issueValid,
    input  logic [31:0]  issueInstr,
    input  logic [31:0]  issueRsValue,
    input  logic [31:0]  issueRtValue,
    input  exceptType_t  issueExcept,
    input  logic         stall,
    input  logic         flush,
    output logic         memValid,
    output exMemBundle_t memBundle
);

    idExBundle_t  issueBundle;
    idExBundle_t  idEx;
    logic         idExValid;
    aluOp_t       aluOp;
    operandSrc_t  bSrc;
    logic         aShamt;
    logic [4:0]   destReg;
    logic         regWrite;
    exceptType_t  exeExcept;
    logic [31:0]  operandA;
    logic [31:0]  operandB;
    logic [31:0]  aluResult;
    logic         overflow;
    exMemBundle_t exBundle;

    assign issueBundle.instr   = issueInstr;
    assign issueBundle.rsValue = issueRsValue;
    assign issueBundle.rtValue = issueRtValue;
    assign issueBundle.except  = issueExcept;

    pipeReg #(.payload_t(idExBundle_t)) idExReg (
        .clk(clk), .reset(reset), .hold(stall), .clear(flush),
        .inValid(issueValid), .inData(issueBundle),
        .outValid(idExValid), .outData(idEx)
    );

    exeControl control (
        .instr(idEx.instr), .inExcept(idEx.except), .overflow(overflow),
        .aluOp(aluOp), .bSrc(bSrc), .aShamt(aShamt),
        .destReg(destReg), .regWrite(regWrite), .outExcept(exeExcept)
    );

    operandSelect opSel (
        .instr(idEx.instr), .rsValue(idEx.rsValue), .rtValue(idEx.rtValue),
        .bSrc(bSrc), .aShamt(aShamt),
        .fwd(memBundle), .fwdValid(memValid), // EX/MEM feedback
        .operandA(operandA), .operandB(operandB)
    );

    alu aluInst (
        .aluOp(aluOp), .operandA(operandA), .operandB(operandB),
        .result(aluResult), .overflow(overflow)
    );

    assign exBundle.aluResult = aluResult;
    assign exBundle.destReg   = destReg;
    assign exBundle.regWrite  = regWrite;
    assign exBundle.except    = exeExcept;

    // flush only reaches ID/EX, the older entry completes
    pipeReg #(.payload_t(exMemBundle_t)) exMemReg (
        .clk(clk), .reset(reset), .hold(stall), .clear(1'b0),
        .inValid(idExValid), .inData(exBundle),
        .outValid(memValid), .outData(memBundle)
    );

endmodule

// File: tests/clockGen.sv
/*
  Free-running clock and synchronous reset for the testbench.
  reset leaves on a rising edge after resetCycles edges.
*/
`timescale 1ns/1ps

module clockGen #(
    parameter int periodNs    = 40,
    parameter int resetCycles = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0; // released on an edge, sync reset
    end

endmodule

// File: tests/executeStageTb.sv
/*
  Table-driven testbench for the execute stage.
  A cycle model follows the two pipeline registers and computes each
  expected EX/MEM entry from the MIPS encodings, with EX/MEM forwarding.
  aluResult and destReg are not compared for reserved instructions.
  Random rows come from $urandom with seed 35.
*/
`timescale 1ns/1ps

module executeStageTb
    import cpuPkg::*;
();

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        exceptType_t exc;
        logic        valid;
        logic        stall;
        logic        flush;
    } stimRow_t;

    localparam logic [95:0] aluFuncts = {FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV,
        FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};

    logic         clk;
    logic         reset;
    logic         issueValid;
    logic [31:0]  issueInstr;
    logic [31:0]  issueRsValue;
    logic [31:0]  issueRtValue;
    exceptType_t  issueExcept;
    logic         stall;
    logic         flush;
    logic         memValid;
    exMemBundle_t memBundle;

    stimRow_t     rows[$];
    idExBundle_t  mId;               // model of ID/EX
    exMemBundle_t mMem;              // model of EX/MEM
    logic         mIdValid  = 1'b0;
    logic         mMemValid = 1'b0;
    int           errors       = 0;
    int           checks       = 0;
    int           validSeen    = 0;
    int           cycleCount   = 0;
    int           timeoutLimit = 1000; // replaced once the table is built

    clockGen #(.periodNs(40), .resetCycles(4)) clkGen (.clk(clk), .reset(reset));

    executeStage UUT (
        .clk(clk), .reset(reset), .issueValid(issueValid), .issueInstr(issueInstr),
        .issueRsValue(issueRsValue), .issueRtValue(issueRtValue), .issueExcept(issueExcept),
        .stall(stall), .flush(flush), .memValid(memValid), .memBundle(memBundle)
    );

    function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                            input logic [4:0] rd, input logic [4:0] sh,
                                            input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // expected EX/MEM entry for one ID/EX entry, older = entry ahead of it
    function automatic exMemBundle_t expectedResult(input idExBundle_t e,
                                                    input logic olderValid,
                                                    input exMemBundle_t older);
        logic [31:0]  a;
        logic [31:0]  b;
        logic [31:0]  se;
        logic [32:0]  wide;
        logic         canFwd;
        logic         rsv;
        logic         ovf;
        exMemBundle_t r;
        se     = {{16{e.instr[15]}}, e.instr[15:0]};
        canFwd = olderValid && older.regWrite && (older.destReg != 5'd0);
        a = (canFwd && older.destReg == e.instr[25:21]) ? older.aluResult : e.rsValue;
        b = (canFwd && older.destReg == e.instr[20:16]) ? older.aluResult : e.rtValue;
        rsv = 1'b0;
        ovf = 1'b0;
        r   = '0;
        r.destReg = e.instr[15:11]; // rd
        if (e.instr[31:26] == 6'h00) begin
            case (e.instr[5:0])
                6'h00: r.aluResult = b << e.instr[10:6];
                6'h02: r.aluResult = b >> e.instr[10:6];
                6'h03: r.aluResult = $signed(b) >>> e.instr[10:6];
                6'h04: r.aluResult = b << a[4:0];
                6'h06: r.aluResult = b >> a[4:0];
                6'h07: r.aluResult = $signed(b) >>> a[4:0];
                6'h20, 6'h22: begin
                    // 33-bit signed add/sub, overflow when top two bits differ
                    wide = e.instr[1] ? ({a[31], a} - {b[31], b}) : ({a[31], a} + {b[31], b});
                    r.aluResult = wide[31:0];
                    ovf = wide[32] ^ wide[31];
                end
                6'h21: r.aluResult = a + b;
                6'h23: r.aluResult = a - b;
                6'h24: r.aluResult = a & b;
                6'h25: r.aluResult = a | b;
                6'h26: r.aluResult = a ^ b;
                6'h27: r.aluResult = ~(a | b);
                6'h2a: r.aluResult = {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
                6'h2b: r.aluResult = {31'd0, a < b};
                default: rsv = 1'b1;
            endcase
        end else begin
            r.destReg = e.instr[20:16]; // rt
            case (e.instr[31:26])
                6'h08: begin
                    wide = {a[31], a} + {se[31], se};
                    r.aluResult = wide[31:0];
                    ovf = wide[32] ^ wide[31];
                end
                6'h09: r.aluResult = a + se;
                6'h0a: r.aluResult = {31'd0, (a[31] != se[31]) ? a[31] : (a < se)};
                6'h0b: r.aluResult = {31'd0, a < se};
                6'h0c: r.aluResult = a & {16'h0000, e.instr[15:0]};
                6'h0d: r.aluResult = a | {16'h0000, e.instr[15:0]};
                6'h0e: r.aluResult = a ^ {16'h0000, e.instr[15:0]};
                6'h0f: r.aluResult = {e.instr[15:0], 16'h0000};
                default: rsv = 1'b1;
            endcase
        end
        r.regWrite = !rsv && !ovf && (r.destReg != 5'd0) && (e.except == '0);
        r.except   = e.except;
        r.except.reservedInstruction = e.except.reservedInstruction | rsv;
        r.except.overflow            = e.except.overflow | ovf;
        return r;
    endfunction

    task automatic addRow(input logic [31:0] instr, input logic [31:0] rsVal,
                          input logic [31:0] rtVal, input exceptType_t exc,
                          input logic valid, input logic stallBit, input logic flushBit);
        stimRow_t r;
        r = '{instr, rsVal, rtVal, exc, valid, stallBit, flushBit};
        rows.push_back(r);
    endtask

    task automatic addOp(input logic [31:0] instr, input logic [31:0] rsVal,
                         input logic [31:0] rtVal);
        addRow(instr, rsVal, rtVal, '0, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        errors++;
        $display("error %s: got %h, expected %h at %0t", name, got, exp, $time);
    endtask

    // model steps with the DUT, reads inputs before this edge's drive lands
    always @(posedge clk) begin
        if (reset) begin
            mIdValid  = 1'b0;
            mMemValid = 1'b0;
        end else begin
            if (!stall) begin
                if (mIdValid) begin
                    mMem = expectedResult(mId, mMemValid, mMem);
                end
                mMemValid = mIdValid;
            end
            if (flush) begin
                mIdValid = 1'b0; // flush wins over stall
            end else if (!stall) begin
                mIdValid = issueValid;
                if (issueValid) begin
                    mId = '{issueInstr, issueRsValue, issueRtValue, issueExcept};
                end
            end
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            checks++;
            if (memValid !== mMemValid) begin
                reportMismatch("memValid", memValid, mMemValid);
            end
            if (mMemValid) begin
                validSeen++;
                if (memBundle.regWrite !== mMem.regWrite) begin
                    reportMismatch("memBundle.regWrite", memBundle.regWrite, mMem.regWrite);
                end
                if (memBundle.except !== mMem.except) begin
                    reportMismatch("memBundle.except", memBundle.except, mMem.except);
                end
                if (!mMem.except.reservedInstruction) begin
                    if (memBundle.aluResult !== mMem.aluResult) begin
                        reportMismatch("memBundle.aluResult", memBundle.aluResult,
                                       mMem.aluResult);
                    end
                    if (memBundle.destReg !== mMem.destReg) begin
                        reportMismatch("memBundle.destReg", memBundle.destReg, mMem.destReg);
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > timeoutLimit) begin
            $display("timeout: run did not finish within %0d cycles", timeoutLimit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        exceptType_t flags;
        logic [5:0]  op;
        void'($urandom(35)); // single seed for the run
        issueValid   = 1'b0;
        issueInstr   = '0;
        issueRsValue = '0;
        issueRtValue = '0;
        issueExcept  = '0;
        stall        = 1'b0;
        flush        = 1'b0;

        addOp(encodeR(1, 2, 3, 0, FN_ADD),  32'h0000_0010, 32'h0000_0020);
        addOp(encodeR(1, 2, 3, 0, FN_ADDU), 32'hffff_fff0, 32'h0000_0011);
        addOp(encodeR(1, 2, 3, 0, FN_SUB),  32'h0000_0005, 32'h0000_0009);
        addOp(encodeR(1, 2, 3, 0, FN_SUBU), 32'h0000_0000, 32'h0000_0001);
        addOp(encodeR(1, 2, 3, 0, FN_AND),  32'hf0f0_1234, 32'h0ff0_ffff);
        addOp(encodeR(1, 2, 3, 0, FN_OR),   32'hf000_0001, 32'h0000_1230);
        addOp(encodeR(1, 2, 3, 0, FN_XOR),  32'hffff_0000, 32'h0f0f_0f0f);
        addOp(encodeR(1, 2, 3, 0, FN_NOR),  32'h1234_0000, 32'h0000_5678);
        addOp(encodeR(1, 2, 3, 0, FN_SLT),  32'hffff_fffe, 32'h0000_0001);
        addOp(encodeR(1, 2, 3, 0, FN_SLTU), 32'hffff_fffe, 32'h0000_0001);
        addOp(encodeI(OP_ADDI, 1, 4, 16'hfff0),  32'h0000_0100, 32'h0);
        addOp(encodeI(OP_ADDIU, 1, 4, 16'h8000), 32'h0000_0100, 32'h0);
        addOp(encodeI(OP_SLTI, 1, 4, 16'hffff),  32'h0000_0005, 32'h0);
        addOp(encodeI(OP_SLTIU, 1, 4, 16'hffff), 32'h0000_0005, 32'h0);
        addOp(encodeI(OP_ANDI, 1, 4, 16'h8001),  32'hffff_ffff, 32'h0);
        addOp(encodeI(OP_ORI, 1, 4, 16'h8001),   32'h1200_0000, 32'h0);
        addOp(encodeI(OP_XORI, 1, 4, 16'hffff),  32'hffff_00ff, 32'h0);
        addOp(encodeI(OP_LUI, 1, 4, 16'h1234),   32'hdead_beef, 32'h0);
        // fixed shifts use shamt, variable ones rs[4:0]
        addOp(encodeR(1, 2, 3, 4, FN_SLL),  32'h0, 32'h0f0f_0001);
        addOp(encodeR(1, 2, 3, 8, FN_SRL),  32'h0, 32'h8000_ff00);
        addOp(encodeR(1, 2, 3, 8, FN_SRA),  32'h0, 32'h8000_ff00);
        addOp(encodeR(1, 2, 3, 0, FN_SLLV), 32'h0000_0023, 32'h0000_0001);
        addOp(encodeR(1, 2, 3, 0, FN_SRLV), 32'hffff_ffe4, 32'h8000_0000);
        addOp(encodeR(1, 2, 3, 0, FN_SRAV), 32'h0000_001f, 32'h8000_0000);
        // overflow traps only on the signed forms
        addOp(encodeR(1, 2, 3, 0, FN_ADD),  32'h7fff_ffff, 32'h0000_0001);
        addOp(encodeR(1, 2, 3, 0, FN_ADDU), 32'h7fff_ffff, 32'h0000_0001);
        addOp(encodeI(OP_ADDI, 1, 4, 16'h0001),  32'h7fff_ffff, 32'h0);
        addOp(encodeI(OP_ADDIU, 1, 4, 16'h0001), 32'h7fff_ffff, 32'h0);
        addOp(encodeR(1, 2, 3, 0, FN_SUB),  32'h8000_0000, 32'h0000_0001);
        addOp(encodeR(1, 2, 3, 0, FN_SUBU), 32'h8000_0000, 32'h0000_0001);
        // dependent pairs, stale register values must lose to forwarding
        addOp(encodeR(1, 2, 5, 0, FN_ADDU), 32'h0000_0100, 32'h0000_0023);
        addOp(encodeR(5, 5, 6, 0, FN_ADDU), 32'hdead_beef, 32'hdead_beef);
        addOp(encodeI(OP_ORI, 6, 7, 16'h000f), 32'hdead_beef, 32'h0);
        addOp(encodeR(1, 2, 0, 0, FN_ADDU), 32'h0000_0005, 32'h0000_0006); // r0 target
        addOp(encodeR(0, 0, 8, 0, FN_ADDU), 32'h0000_0000, 32'h0000_0000);
        addOp(encodeR(1, 2, 9, 0, FN_ADD),  32'h7fff_ffff, 32'h0000_0001); // write killed
        addOp(encodeR(9, 9, 10, 0, FN_ADDU), 32'h0000_0001, 32'h0000_0002);
        // reserved encodings and incoming flags
        addOp({6'h3f, 26'h0}, 32'h1, 32'h2);
        addOp(encodeR(1, 2, 3, 0, 6'h3f), 32'h1, 32'h2);
        flags = '0;
        flags.syscall = 1'b1;
        addRow(encodeR(1, 2, 11, 0, FN_ADDU), 32'h1, 32'h2, flags, 1'b1, 1'b0, 1'b0);
        addOp(encodeR(11, 0, 12, 0, FN_ADDU), 32'h7, 32'h0);
        flags = '0;
        flags.wrongAddressInIf = 1'b1;
        flags.overflow         = 1'b1;
        addRow(encodeI(OP_ORI, 1, 4, 16'h00f0), 32'h1, 32'h0, flags, 1'b1, 1'b0, 1'b0);
        // stall ignores the issue inputs, flush drops the new entry
        addOp(encodeR(1, 2, 13, 0, FN_ADDU), 32'h0000_0040, 32'h0000_0002);
        addRow(encodeR(1, 2, 14, 0, FN_ADDU), 32'h99, 32'h99, '0, 1'b1, 1'b1, 1'b0);
        addRow(encodeR(1, 2, 14, 0, FN_ADDU), 32'h99, 32'h99, '0, 1'b1, 1'b1, 1'b0);
        addOp(encodeR(13, 2, 15, 0, FN_ADDU), 32'h0, 32'h3);
        addRow(encodeR(1, 2, 16, 0, FN_ADDU), 32'h5, 32'h5, '0, 1'b1, 1'b0, 1'b1);
        // r15 still sits in EX/MEM but marked invalid, must not forward
        addOp(encodeR(16, 15, 17, 0, FN_ADDU), 32'h10, 32'h1);
        // random ops on a few registers so forwarding shows up often
        for (int k = 0; k < 16; k++) begin
            op = 6'h08 + 6'($urandom % 8);
            if ($urandom % 2) begin
                addOp(encodeR(5'($urandom % 8), 5'($urandom % 8), 5'($urandom % 8),
                              5'($urandom % 32), aluFuncts[6 * ($urandom % 16) +: 6]),
                      $urandom, $urandom);
            end else begin
                addOp(encodeI(op, 5'($urandom % 8), 5'($urandom % 8), 16'($urandom)),
                      $urandom, $urandom);
            end
        end
        timeoutLimit = rows.size() + 20;

        @(negedge reset);
        foreach (rows[i]) begin
            @(posedge clk);
            issueValid   <= rows[i].valid;
            issueInstr   <= rows[i].instr;
            issueRsValue <= rows[i].rsVal;
            issueRtValue <= rows[i].rtVal;
            issueExcept  <= rows[i].exc;
            stall        <= rows[i].stall;
            flush        <= rows[i].flush;
        end
        @(posedge clk);
        issueValid <= 1'b0;
        stall      <= 1'b0;
        flush      <= 1'b0;
        @(negedge clk);
        while (mIdValid || mMemValid || issueValid) begin
            @(negedge clk);
        end
        @(posedge clk); // last falling-edge check is done
        if (validSeen == 0) begin
            errors++;
            $display("no valid result ever reached memBundle");
        end
        $display("checks: %0d, valid cycles compared: %0d, errors: %0d",
                 checks, validSeen, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
verilog/cpuPkg.sv
verilog/pipeReg.sv
verilog/exeControl.sv
verilog/operandSelect.sv
verilog/alu.sv
verilog/executeStage.sv
tests/clockGen.sv
tests/executeStageTb.sv

// File: Bender.yml
package:
  name: execute_stage

sources:
  - verilog/cpuPkg.sv
  - verilog/pipeReg.sv
  - verilog/exeControl.sv
  - verilog/operandSelect.sv
  - verilog/alu.sv
  - verilog/executeStage.sv
  - target: test
    files:
      - tests/clockGen.sv
      - tests/executeStageTb.sv
